//--- Makefile
# Verilator simulation of the issue front end
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = issue_front_tb
FILELIST  = sources.f
OBJDIR    = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: sim clean

# the run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- dv/issue_front_tb.sv
/*
 * issue front end testbench
 * applies a table of instructions, acks, flushes and writebacks and
 * checks names and operands against a model of the tables and files
 */
module issue_front_tb;

    // one table row, applied on a rising edge
    typedef struct {
        issue_pkg::instr_t    instr;
        logic                 ival;
        logic                 ack;
        logic                 flush;
        logic                 flush_un;
        logic                 wb_en;
        logic                 wb_fpr;
        issue_pkg::phys_reg_t wb_rd;
        issue_pkg::data_t     wb_data;
        logic                 chk;
    } row_t;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 flush_i;
    logic                 flush_unissued_i;
    logic                 instr_valid_i;
    issue_pkg::instr_t    instr_i;
    logic                 instr_ack_o;
    issue_pkg::op_e       op_o;
    issue_pkg::phys_reg_t rd_o, rs1_o, rs2_o, rs3_o;
    issue_pkg::data_t     rs1_data_o, rs2_data_o, rs3_data_o;
    logic                 issue_valid_o;
    logic                 issue_ack_i;
    logic                 wb_valid_i;
    logic                 wb_fpr_i;
    issue_pkg::phys_reg_t wb_rd_i;
    issue_pkg::data_t     wb_data_i;

    row_t   rows [64];
    int     n_rows = 0;
    int     errors = 0;
    int     checks = 0;
    integer seed;
    logic   table_ready = 1'b0;

    // model of the toggle tables and physical files
    logic [31:0]      m_gtbl;
    logic [31:0]      m_ftbl;
    issue_pkg::data_t m_grf [64];
    issue_pkg::data_t m_frf [64];

    issue_front_top #(
        .RenameEn (1'b1)
    ) u_dut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .flush_unissued_i (flush_unissued_i),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .instr_ack_o      (instr_ack_o),
        .op_o             (op_o),
        .rd_o             (rd_o),
        .rs1_o            (rs1_o),
        .rs2_o            (rs2_o),
        .rs3_o            (rs3_o),
        .rs1_data_o       (rs1_data_o),
        .rs2_data_o       (rs2_data_o),
        .rs3_data_o       (rs3_data_o),
        .issue_valid_o    (issue_valid_o),
        .issue_ack_i      (issue_ack_i),
        .wb_valid_i       (wb_valid_i),
        .wb_fpr_i         (wb_fpr_i),
        .wb_rd_i          (wb_rd_i),
        .wb_data_i        (wb_data_i)
    );

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // table building
    // ------------------------------------------------------------
    function automatic issue_pkg::instr_t enc(input logic [5:0] opc, input int rd,
                                              input int rs1, input int rs2, input int rs3);
        return {opc, rd[4:0], rs1[4:0], rs2[4:0], rs3[4:0], 6'b0};
    endfunction

    task automatic add_row(input issue_pkg::instr_t instr, input int ival, input int ack,
                           input int fl, input int flu, input int wbe, input int wbf,
                           input int wbrd, input int chk);
        rows[n_rows].instr    = instr;
        rows[n_rows].ival     = (ival != 0);
        rows[n_rows].ack      = (ack != 0);
        rows[n_rows].flush    = (fl != 0);
        rows[n_rows].flush_un = (flu != 0);
        rows[n_rows].wb_en    = (wbe != 0);
        rows[n_rows].wb_fpr   = (wbf != 0);
        rows[n_rows].wb_rd    = wbrd[5:0];
        // writeback data is random, drawn row by row
        rows[n_rows].wb_data  = $random(seed);
        rows[n_rows].chk      = (chk != 0);
        n_rows++;
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic fp_dest(input issue_pkg::op_e op);
        return op inside {issue_pkg::op_fadd, issue_pkg::op_fmadd, issue_pkg::op_fmv_f};
    endfunction

    function automatic logic fp_src1(input issue_pkg::op_e op);
        return op inside {issue_pkg::op_fadd, issue_pkg::op_fmadd, issue_pkg::op_fmv_x};
    endfunction

    function automatic logic fp_src2(input issue_pkg::op_e op);
        return op inside {issue_pkg::op_fadd, issue_pkg::op_fmadd};
    endfunction

    function automatic logic fp_src3(input issue_pkg::op_e op);
        return op == issue_pkg::op_fmadd;
    endfunction

    // unknown opcodes become nop, unused fields read as zero
    task automatic decode_ref(input issue_pkg::instr_t w, output issue_pkg::op_e op,
                              output issue_pkg::arch_reg_t rd, output issue_pkg::arch_reg_t rs1,
                              output issue_pkg::arch_reg_t rs2, output issue_pkg::arch_reg_t rs3);
        op = issue_pkg::op_e'(w[31:26]);
        if (!(op inside {issue_pkg::op_alu, issue_pkg::op_load, issue_pkg::op_fadd,
                         issue_pkg::op_fmadd, issue_pkg::op_fmv_x, issue_pkg::op_fmv_f})) begin
            op = issue_pkg::op_nop;
        end
        rd  = (op != issue_pkg::op_nop) ? w[25:21] : 5'd0;
        rs1 = (op != issue_pkg::op_nop) ? w[20:16] : 5'd0;
        rs2 = (op inside {issue_pkg::op_alu, issue_pkg::op_fadd, issue_pkg::op_fmadd}) ?
              w[15:11] : 5'd0;
        rs3 = fp_src3(op) ? w[10:6] : 5'd0;
    endtask

    // gpr physical 0 always reads zero
    function automatic issue_pkg::data_t read_ref(input logic is_fp,
                                                  input issue_pkg::phys_reg_t name);
        if (is_fp) begin
            return m_frf[name];
        end
        return (name == 6'd0) ? '0 : m_grf[name];
    endfunction

    // applies the edge that ends a row: table toggle or flush, then writeback
    task automatic step_ref(input row_t r);
        issue_pkg::op_e       op;
        issue_pkg::arch_reg_t rd, rs1, rs2, rs3;
        decode_ref(r.instr, op, rd, rs1, rs2, rs3);
        if (r.flush) begin
            m_gtbl = '0;
            m_ftbl = '0;
        end else if (r.ival && r.ack && !r.flush_un && op != issue_pkg::op_nop) begin
            if (fp_dest(op)) begin
                m_ftbl[rd] = ~m_ftbl[rd];
            end else if (rd != 5'd0) begin
                m_gtbl[rd] = ~m_gtbl[rd];
            end
        end
        if (r.wb_en && r.wb_fpr) begin
            m_frf[r.wb_rd] = r.wb_data;
        end else if (r.wb_en && r.wb_rd != 6'd0) begin
            m_grf[r.wb_rd] = r.wb_data;
        end
    endtask

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_phys(input string what, input issue_pkg::phys_reg_t got,
                              input issue_pkg::phys_reg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input string what, input issue_pkg::data_t got,
                              input issue_pkg::data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_op(input issue_pkg::op_e got, input issue_pkg::op_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: op is %s, expected %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_row(input row_t r);
        issue_pkg::op_e       op;
        issue_pkg::arch_reg_t rd, rs1, rs2, rs3;
        issue_pkg::phys_reg_t e_rd, e_rs1, e_rs2, e_rs3;
        decode_ref(r.instr, op, rd, rs1, rs2, rs3);
        // sources see the current bit, the destination the toggled one
        e_rs1 = {fp_src1(op) ? m_ftbl[rs1] : m_gtbl[rs1], rs1};
        e_rs2 = {fp_src2(op) ? m_ftbl[rs2] : m_gtbl[rs2], rs2};
        e_rs3 = {fp_src3(op) & m_ftbl[rs3], rs3};
        if (fp_dest(op)) begin
            e_rd = {~m_ftbl[rd], rd};
        end else if (rd == 5'd0) begin
            e_rd = 6'd0;
        end else begin
            e_rd = {~m_gtbl[rd], rd};
        end
        check_op(op_o, op);
        check_phys("rd", rd_o, e_rd);
        check_phys("rs1", rs1_o, e_rs1);
        check_phys("rs2", rs2_o, e_rs2);
        check_phys("rs3", rs3_o, e_rs3);
        check_data("rs1 data", rs1_data_o, read_ref(fp_src1(op), e_rs1));
        check_data("rs2 data", rs2_data_o, read_ref(fp_src2(op), e_rs2));
        check_data("rs3 data", rs3_data_o, read_ref(1'b1, e_rs3));
        check_flag("issue valid", issue_valid_o, r.ival);
        check_flag("instr ack", instr_ack_o, r.ack);
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------
    // columns: instr, valid, ack, flush, flush_unissued, wb en, wb fpr, wb name, check
    task automatic build_table();
        // x0 stays at physical 0 and reads zero, other half of x8 not read
        add_row(enc(issue_pkg::op_nop, 0, 0, 0, 0), 0, 0, 0, 0, 1, 0, 8, 1);
        add_row(enc(issue_pkg::op_alu, 1, 0, 8, 0), 1, 1, 0, 0, 1, 0, 0, 1);
        add_row(enc(issue_pkg::op_alu, 0, 1, 0, 0), 1, 1, 0, 0, 1, 0, 40, 1);
        add_row(enc(issue_pkg::op_alu, 2, 8, 1, 0), 1, 1, 0, 0, 0, 0, 0, 1);
        // repeated writes to x5 alternate halves
        add_row(enc(issue_pkg::op_alu, 5, 2, 2, 0), 1, 1, 0, 0, 1, 0, 37, 1);
        add_row(enc(issue_pkg::op_alu, 6, 5, 5, 0), 1, 1, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_alu, 5, 6, 1, 0), 1, 1, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_alu, 7, 5, 0, 0), 1, 1, 0, 0, 1, 0, 5, 1);
        add_row(enc(issue_pkg::op_load, 9, 5, 3, 0), 1, 1, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_alu, 5, 5, 9, 0), 1, 1, 0, 0, 0, 0, 0, 1);
        // fp table apart from the gpr table, moves and rs3
        add_row(enc(issue_pkg::op_fadd, 5, 1, 2, 0), 1, 1, 0, 0, 1, 1, 1, 1);
        add_row(enc(issue_pkg::op_fmv_x, 3, 1, 0, 0), 1, 1, 0, 0, 1, 1, 37, 1);
        add_row(enc(issue_pkg::op_fmv_f, 3, 5, 0, 0), 1, 1, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_fmadd, 4, 1, 3, 5), 1, 1, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_fadd, 6, 4, 4, 0), 1, 1, 0, 0, 1, 1, 36, 1);
        // back-pressure, then an acked but unissued instruction
        add_row(enc(issue_pkg::op_alu, 10, 5, 3, 0), 1, 0, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_alu, 10, 5, 3, 0), 1, 0, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_fadd, 7, 4, 5, 0), 1, 0, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_alu, 10, 5, 3, 0), 0, 0, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_alu, 10, 5, 3, 0), 1, 1, 0, 1, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_alu, 11, 10, 10, 0), 1, 1, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_fmadd, 4, 6, 5, 4), 1, 1, 0, 1, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_fadd, 8, 4, 4, 0), 1, 1, 0, 0, 0, 0, 0, 1);
        // full flush overrides the update of its own cycle
        add_row(enc(issue_pkg::op_alu, 12, 5, 11, 0), 1, 1, 1, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_alu, 13, 5, 11, 0), 1, 1, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_fadd, 9, 5, 4, 0), 1, 1, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_fmadd, 2, 1, 3, 6), 1, 1, 0, 0, 1, 1, 0, 1);
        // unknown opcode turns into a nop
        add_row(enc(6'h3f, 9, 9, 9, 9), 1, 1, 0, 0, 0, 0, 0, 1);
        add_row(enc(issue_pkg::op_fmv_x, 11, 5, 0, 0), 1, 1, 0, 0, 0, 0, 0, 1);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        flush_unissued_i = 1'b0;
        instr_valid_i    = 1'b0;
        instr_i          = '0;
        issue_ack_i      = 1'b0;
        wb_valid_i       = 1'b0;
        wb_fpr_i         = 1'b0;
        wb_rd_i          = '0;
        wb_data_i        = '0;
        seed             = 74;
        m_gtbl           = '0;
        m_ftbl           = '0;
        for (int k = 0; k < 64; k++) begin
            m_grf[k] = '0;
            m_frf[k] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk_i);
            instr_i          <= rows[i].instr;
            instr_valid_i    <= rows[i].ival;
            issue_ack_i      <= rows[i].ack;
            flush_i          <= rows[i].flush;
            flush_unissued_i <= rows[i].flush_un;
            wb_valid_i       <= rows[i].wb_en;
            wb_fpr_i         <= rows[i].wb_fpr;
            wb_rd_i          <= rows[i].wb_rd;
            wb_data_i        <= rows[i].wb_data;
            // outputs are combinational, settled by the falling edge
            @(negedge clk_i);
            if (rows[i].chk) begin
                check_row(rows[i]);
            end
            step_ref(rows[i]);
        end
        @(posedge clk_i);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog, sized from the table length
    initial begin
        wait (table_ready === 1'b1);
        #((n_rows + 10) * 40);
        $display("watchdog: the run timed out before the table was done");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- rtl/instr_decoder.sv
/*
 * instruction decoder
 * splits the word into the operation and the register fields,
 * maps unknown opcodes to nop and zeroes every unused field
 */
module instr_decoder (
    input  issue_pkg::instr_t    instr_i,
    input  logic                 instr_valid_i,
    output issue_pkg::op_e       op_o,
    output issue_pkg::arch_reg_t rd_o,
    output issue_pkg::arch_reg_t rs1_o,
    output issue_pkg::arch_reg_t rs2_o,
    output issue_pkg::arch_reg_t rs3_o,
    output logic                 valid_o
);

    // raw fields straight from the word
    logic [5:0]           opcode;
    issue_pkg::arch_reg_t rd_raw;
    issue_pkg::arch_reg_t rs1_raw;
    issue_pkg::arch_reg_t rs2_raw;
    issue_pkg::arch_reg_t rs3_raw;

    // decoded operation and field usage
    issue_pkg::op_e op;
    logic           use_rd;
    logic           use_rs1;
    logic           use_rs2;
    logic           use_rs3;

    // ------------------------------------------------------------
    // field extraction
    // ------------------------------------------------------------
    assign opcode  = instr_i[issue_pkg::opcode_lsb +: 6];
    assign rd_raw  = instr_i[issue_pkg::rd_lsb +: 5];
    assign rs1_raw = instr_i[issue_pkg::rs1_lsb +: 5];
    assign rs2_raw = instr_i[issue_pkg::rs2_lsb +: 5];
    assign rs3_raw = instr_i[issue_pkg::rs3_lsb +: 5];

    // ------------------------------------------------------------
    // operation decode
    // ------------------------------------------------------------
    always_comb begin
        // anything not listed degrades to a nop touching no register
        op      = issue_pkg::op_nop;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rs3 = 1'b0;
        unique case (opcode)
            issue_pkg::op_alu,
            issue_pkg::op_fadd: begin
                // two sources, one destination, same class
                op      = issue_pkg::op_e'(opcode);
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            issue_pkg::op_load,
            issue_pkg::op_fmv_x,
            issue_pkg::op_fmv_f: begin
                // single source, rs2 left at zero
                op      = issue_pkg::op_e'(opcode);
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            issue_pkg::op_fmadd: begin
                op      = issue_pkg::op_fmadd;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rs3 = 1'b1;
            end
            default: begin
                op = issue_pkg::op_nop;
            end
        endcase
    end

    // unused sources read register 0, a nop targets gpr 0 which is never renamed
    assign op_o    = op;
    assign rd_o    = use_rd  ? rd_raw  : '0;
    assign rs1_o   = use_rs1 ? rs1_raw : '0;
    assign rs2_o   = use_rs2 ? rs2_raw : '0;
    assign rs3_o   = use_rs3 ? rs3_raw : '0;
    assign valid_o = instr_valid_i;

endmodule

//--- rtl/issue_front_top.sv
/*
 * issue front end top level
 * decode, rename and operand read chained in one cycle
 */
module issue_front_top #(
    parameter bit RenameEn = 1'b1
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 flush_unissued_i,
    // instruction in
    input  logic                 instr_valid_i,
    input  issue_pkg::instr_t    instr_i,
    output logic                 instr_ack_o,
    // issue out
    output issue_pkg::op_e       op_o,
    output issue_pkg::phys_reg_t rd_o,
    output issue_pkg::phys_reg_t rs1_o,
    output issue_pkg::phys_reg_t rs2_o,
    output issue_pkg::phys_reg_t rs3_o,
    output issue_pkg::data_t     rs1_data_o,
    output issue_pkg::data_t     rs2_data_o,
    output issue_pkg::data_t     rs3_data_o,
    output logic                 issue_valid_o,
    input  logic                 issue_ack_i,
    // writeback
    input  logic                 wb_valid_i,
    input  logic                 wb_fpr_i,
    input  issue_pkg::phys_reg_t wb_rd_i,
    input  issue_pkg::data_t     wb_data_i
);

    // ------------------------------------------------------------
    // decoder to renamer
    // ------------------------------------------------------------
    issue_pkg::op_e       dec_op;
    issue_pkg::arch_reg_t dec_rd;
    issue_pkg::arch_reg_t dec_rs1;
    issue_pkg::arch_reg_t dec_rs2;
    issue_pkg::arch_reg_t dec_rs3;
    logic                 dec_valid;

    // renamer to reader
    issue_pkg::op_e       ren_op;
    issue_pkg::phys_reg_t ren_rd;
    issue_pkg::phys_reg_t ren_rs1;
    issue_pkg::phys_reg_t ren_rs2;
    issue_pkg::phys_reg_t ren_rs3;
    logic                 ren_valid;
    // ack travels back from the reader
    logic                 rd_ack;

    instr_decoder u_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .op_o          (dec_op),
        .rd_o          (dec_rd),
        .rs1_o         (dec_rs1),
        .rs2_o         (dec_rs2),
        .rs3_o         (dec_rs3),
        .valid_o       (dec_valid)
    );

    reg_renamer #(
        .RenameEn (RenameEn)
    ) u_renamer (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .flush_unissued_i (flush_unissued_i),
        .op_i             (dec_op),
        .rd_i             (dec_rd),
        .rs1_i            (dec_rs1),
        .rs2_i            (dec_rs2),
        .rs3_i            (dec_rs3),
        .valid_i          (dec_valid),
        .ack_o            (instr_ack_o),
        .op_o             (ren_op),
        .rd_o             (ren_rd),
        .rs1_o            (ren_rs1),
        .rs2_o            (ren_rs2),
        .rs3_o            (ren_rs3),
        .valid_o          (ren_valid),
        .ack_i            (rd_ack)
    );

    operand_reader u_reader (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .op_i          (ren_op),
        .rd_i          (ren_rd),
        .rs1_i         (ren_rs1),
        .rs2_i         (ren_rs2),
        .rs3_i         (ren_rs3),
        .valid_i       (ren_valid),
        .ack_o         (rd_ack),
        .op_o          (op_o),
        .rd_o          (rd_o),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .rs3_o         (rs3_o),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .rs3_data_o    (rs3_data_o),
        .issue_valid_o (issue_valid_o),
        .ack_i         (issue_ack_i),
        .wb_valid_i    (wb_valid_i),
        .wb_fpr_i      (wb_fpr_i),
        .wb_rd_i       (wb_rd_i),
        .wb_data_i     (wb_data_i)
    );

endmodule

//--- rtl/issue_pkg.sv
/*
 * issue front end shared definitions
 * register types, operation encoding, instruction field layout
 * and the helpers that tell which register class an operand uses
 */
package issue_pkg;

    // ------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------
    // raw instruction word
    typedef logic [31:0] instr_t;
    // architectural register address, one of 32 per class
    typedef logic [4:0]  arch_reg_t;
    // physical name, msb is the rename bit
    typedef logic [5:0]  phys_reg_t;
    // operand and writeback data
    typedef logic [31:0] data_t;

    // operation encoding, lives in the top 6 bits of the word
    typedef enum logic [5:0] {
        op_nop   = 6'h00,
        op_alu   = 6'h01,
        op_load  = 6'h02,
        op_fadd  = 6'h10,
        op_fmadd = 6'h11,
        op_fmv_x = 6'h12,
        op_fmv_f = 6'h13
    } op_e;

    // ------------------------------------------------------------
    // instruction field layout, lsb of each field
    // ------------------------------------------------------------
    // bits [5:0] are not used by this front end
    localparam int unsigned opcode_lsb = 26;
    localparam int unsigned rd_lsb     = 21;
    localparam int unsigned rs1_lsb    = 16;
    localparam int unsigned rs2_lsb    = 11;
    localparam int unsigned rs3_lsb    = 6;

    // ------------------------------------------------------------
    // register class helpers
    // ------------------------------------------------------------
    // destination lives in the fp file
    function automatic logic rd_is_fpr(input op_e op);
        return (op == op_fadd) || (op == op_fmadd) || (op == op_fmv_f);
    endfunction

    // first source comes from the fp file, fmv_x moves fp to int
    function automatic logic rs1_is_fpr(input op_e op);
        return (op == op_fadd) || (op == op_fmadd) || (op == op_fmv_x);
    endfunction

    // second source only exists as fp for the arithmetic fp ops
    function automatic logic rs2_is_fpr(input op_e op);
        return (op == op_fadd) || (op == op_fmadd);
    endfunction

    // third source, always fp, only for the fused multiply add
    function automatic logic uses_rs3(input op_e op);
        return op == op_fmadd;
    endfunction

endpackage

//--- rtl/operand_reader.sv
/*
 * operand reader
 * 64 entry integer and fp physical register files, filled by the
 * writeback port and read by physical name for issue
 */
module operand_reader (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // from renamer
    input  issue_pkg::op_e       op_i,
    input  issue_pkg::phys_reg_t rd_i,
    input  issue_pkg::phys_reg_t rs1_i,
    input  issue_pkg::phys_reg_t rs2_i,
    input  issue_pkg::phys_reg_t rs3_i,
    input  logic                 valid_i,
    output logic                 ack_o,
    // to issue
    output issue_pkg::op_e       op_o,
    output issue_pkg::phys_reg_t rd_o,
    output issue_pkg::phys_reg_t rs1_o,
    output issue_pkg::phys_reg_t rs2_o,
    output issue_pkg::phys_reg_t rs3_o,
    output issue_pkg::data_t     rs1_data_o,
    output issue_pkg::data_t     rs2_data_o,
    output issue_pkg::data_t     rs3_data_o,
    output logic                 issue_valid_o,
    input  logic                 ack_i,
    // writeback
    input  logic                 wb_valid_i,
    input  logic                 wb_fpr_i,
    input  issue_pkg::phys_reg_t wb_rd_i,
    input  issue_pkg::data_t     wb_data_i
);

    // physical register files, both halves of every pair
    issue_pkg::data_t gpr_rf_q [64];
    issue_pkg::data_t fpr_rf_q [64];

    // read one source from the file of its class
    function automatic issue_pkg::data_t read_src(
        input logic                 is_fpr,
        input issue_pkg::phys_reg_t name
    );
        issue_pkg::data_t val;
        if (is_fpr) begin
            val = fpr_rf_q[name];
        end else if (name == '0) begin
            // x0 always reads zero
            val = '0;
        end else begin
            val = gpr_rf_q[name];
        end
        return val;
    endfunction

    // ------------------------------------------------------------
    // pass through of names and handshake
    // ------------------------------------------------------------
    assign op_o          = op_i;
    assign rd_o          = rd_i;
    assign rs1_o         = rs1_i;
    assign rs2_o         = rs2_i;
    assign rs3_o         = rs3_i;
    assign issue_valid_o = valid_i;
    assign ack_o         = ack_i;

    // ------------------------------------------------------------
    // operand read
    // ------------------------------------------------------------
    // no bypass, a writeback shows up one cycle later
    assign rs1_data_o = read_src(issue_pkg::rs1_is_fpr(op_i), rs1_i);
    assign rs2_data_o = read_src(issue_pkg::rs2_is_fpr(op_i), rs2_i);
    // rs3 is fp only, unused slots point at fpr 0
    assign rs3_data_o = read_src(1'b1, rs3_i);

    // ------------------------------------------------------------
    // writeback
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < 64; i++) begin
                gpr_rf_q[i] <= '0;
                fpr_rf_q[i] <= '0;
            end
        end else if (wb_valid_i) begin
            if (wb_fpr_i) begin
                fpr_rf_q[wb_rd_i] <= wb_data_i;
            end else if (wb_rd_i != '0) begin
                // writes to x0 are dropped
                gpr_rf_q[wb_rd_i] <= wb_data_i;
            end
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // downstream may only acknowledge an instruction on offer
    ack_needs_valid_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni) ack_i |-> valid_i
    );

endmodule

//--- rtl/reg_renamer.sv
/*
 * register renamer
 * one toggle bit per architectural register and class extends
 * each 5 bit address to a 6 bit physical name
 */
module reg_renamer #(
    parameter bit RenameEn = 1'b1
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 flush_unissued_i,
    // from decoder
    input  issue_pkg::op_e       op_i,
    input  issue_pkg::arch_reg_t rd_i,
    input  issue_pkg::arch_reg_t rs1_i,
    input  issue_pkg::arch_reg_t rs2_i,
    input  issue_pkg::arch_reg_t rs3_i,
    input  logic                 valid_i,
    output logic                 ack_o,
    // to operand reader
    output issue_pkg::op_e       op_o,
    output issue_pkg::phys_reg_t rd_o,
    output issue_pkg::phys_reg_t rs1_o,
    output issue_pkg::phys_reg_t rs2_o,
    output issue_pkg::phys_reg_t rs3_o,
    output logic                 valid_o,
    input  logic                 ack_i
);

    // toggle tables with one bit per architectural register
    logic [31:0] gpr_tbl_q;
    logic [31:0] gpr_tbl_d;
    logic [31:0] fpr_tbl_q;
    logic [31:0] fpr_tbl_d;

    // name bits picked for this instruction
    logic bit_rs1;
    logic bit_rs2;
    logic bit_rs3;
    logic bit_rd;

    logic take;
    logic has_rd;

    // handshake goes straight through
    assign valid_o = valid_i;
    assign ack_o   = ack_i;
    assign op_o    = op_i;

    assign take   = valid_i & ack_i;
    assign has_rd = op_i != issue_pkg::op_nop;

    // ------------------------------------------------------------
    // name selection
    // ------------------------------------------------------------
    // sources see the current table state
    assign bit_rs1 = issue_pkg::rs1_is_fpr(op_i) ? fpr_tbl_q[rs1_i] : gpr_tbl_q[rs1_i];
    assign bit_rs2 = issue_pkg::rs2_is_fpr(op_i) ? fpr_tbl_q[rs2_i] : gpr_tbl_q[rs2_i];
    // rs3 only carries a rename bit when it is a real operand
    assign bit_rs3 = issue_pkg::uses_rs3(op_i) ? fpr_tbl_q[rs3_i] : 1'b0;
    // destination sees the state after the update and x0 keeps its name
    assign bit_rd  = issue_pkg::rd_is_fpr(op_i) ? ~fpr_tbl_q[rd_i]
                                                : gpr_tbl_q[rd_i] ^ (rd_i != '0);

    assign rs1_o = {RenameEn & bit_rs1, rs1_i};
    assign rs2_o = {RenameEn & bit_rs2, rs2_i};
    assign rs3_o = {RenameEn & bit_rs3, rs3_i};
    assign rd_o  = {RenameEn & bit_rd, rd_i};

    // ------------------------------------------------------------
    // table update
    // ------------------------------------------------------------
    always_comb begin
        gpr_tbl_d = gpr_tbl_q;
        fpr_tbl_d = fpr_tbl_q;
        // flip the destination bit once the instruction is taken
        if (take && has_rd && !flush_unissued_i) begin
            if (issue_pkg::rd_is_fpr(op_i)) begin
                fpr_tbl_d[rd_i] = ~fpr_tbl_q[rd_i];
            end else begin
                gpr_tbl_d[rd_i] = ~gpr_tbl_q[rd_i];
            end
        end
        // x0 is hardwired and never renamed
        gpr_tbl_d[0] = 1'b0;
        // full flush wins over any update
        if (flush_i) begin
            gpr_tbl_d = '0;
            fpr_tbl_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gpr_tbl_q <= '0;
            fpr_tbl_q <= '0;
        end else begin
            gpr_tbl_q <= gpr_tbl_d;
            fpr_tbl_q <= fpr_tbl_d;
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    gpr_zero_never_renamed_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni) gpr_tbl_q[0] == 1'b0
    );

endmodule

//--- sources.f
rtl/issue_pkg.sv
rtl/instr_decoder.sv
rtl/reg_renamer.sv
rtl/operand_reader.sv
rtl/issue_front_top.sv
dv/issue_front_tb.sv
